/* all.f */
sram_pkg.sv
wb_decoder.sv
sram_ctrl.sv
sram_regs.sv
wb_responder.sv
sram_subsystem.sv
sram_model.sv
tb_sram_subsystem.sv

/* tb_sram_subsystem.sv */
module tb_sram_subsystem;
    import sram_pkg::*;

    typedef enum {OP_WRITE, OP_READ, OP_CHECK_READS, OP_CHECK_WRITES} op_e;

    logic                      wb_clock = 1'b0;
    logic                      wb_reset;
    logic [BUS_ADDR_WIDTH-1:0] wb_addr;
    logic [DATA_WIDTH-1:0]     wb_wdata;
    logic                      wb_we;
    logic                      wb_cycle;
    logic                      wb_strobe;
    logic                      wb_stall;
    logic                      wb_ack;
    logic [DATA_WIDTH-1:0]     wb_rdata;
    logic [RAM_ADDR_WIDTH-1:0] sram_addr;
    logic [DATA_WIDTH-1:0]     sram_rdata;
    logic [DATA_WIDTH-1:0]     sram_wdata;
    logic                      sram_data_oe;
    logic                      sram_oe;
    logic                      sram_we;
    int                        violations;

    // Stimulus table, one column per queue
    string                     names[$];
    op_e                       ops[$];
    logic [BUS_ADDR_WIDTH-1:0] addrs[$];
    logic [DATA_WIDTH-1:0]     wdatas[$];
    logic [DATA_WIDTH-1:0]     expects[$];

    int errors = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int accepts = 0;
    int acks = 0;
    int issued = 0;
    int sram_reads = 0;
    int sram_writes = 0;

    always #5 wb_clock = ~wb_clock;

    sram_subsystem DUT (
        .wb_clock_i (wb_clock), .wb_reset_i (wb_reset),
        .wb_addr_i (wb_addr), .wb_data_i (wb_wdata), .wb_we_i (wb_we),
        .wb_cycle_i (wb_cycle), .wb_strobe_i (wb_strobe), .wb_stall_o (wb_stall),
        .wb_ack_o (wb_ack), .wb_data_o (wb_rdata),
        .sram_addr_o (sram_addr), .sram_data_i (sram_rdata), .sram_data_o (sram_wdata),
        .sram_data_oe_o (sram_data_oe), .sram_oe_o (sram_oe), .sram_we_o (sram_we)
    );

    sram_model chip (
        .clock_i (wb_clock), .addr_i (sram_addr), .data_i (sram_wdata),
        .data_oe_i (sram_data_oe), .oe_i (sram_oe), .we_i (sram_we),
        .data_o (sram_rdata), .violations_o (violations)
    );

    // Handshakes counted on the falling edge, where the bus is settled
    always @(negedge wb_clock) begin
        if (!wb_reset && wb_cycle && wb_strobe && !wb_stall) accepts++;
        if (!wb_reset && wb_ack) acks++;
    end

    always @(posedge wb_clock) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(input string name, input op_e op, input logic [17:0] addr,
                             input logic [7:0] wdata, input logic [7:0] expected);
        names.push_back(name);
        ops.push_back(op);
        addrs.push_back(addr);
        wdatas.push_back(wdata);
        expects.push_back(expected);
    endtask

    // One bus request, strobe left high for the next one
    task automatic access(input logic we, input logic [17:0] addr, input logic [7:0] wdata,
                          output logic [7:0] rdata);
        wb_addr   = addr;
        wb_wdata  = wdata;
        wb_we     = we;
        wb_cycle  = 1'b1;
        wb_strobe = 1'b1;
        @(negedge wb_clock);
        while (wb_stall) @(negedge wb_clock);
        // Accepted on this edge
        @(posedge wb_clock);
        @(negedge wb_clock);
        while (!wb_ack) @(negedge wb_clock);
        rdata = wb_rdata;
        @(posedge wb_clock);
        #1;
        issued++;
        if (!addr[BUS_ADDR_WIDTH-1] && we) sram_writes++;
        if (!addr[BUS_ADDR_WIDTH-1] && !we) sram_reads++;
    endtask

    task automatic check_read(input string name, input logic [17:0] addr,
                              input logic [7:0] want);
        logic [7:0] got;
        access(1'b0, addr, 8'h00, got);
        if (got !== want) begin
            $display("mismatch %s: expected %02h, actual %02h", name, want, got);
            errors++;
        end
    endtask

    task automatic build_table();
        add_entry("reset scratch", OP_READ, 18'h20000, 8'h00, 8'h00);
        add_entry("reset read count", OP_CHECK_READS, 18'h20001, 8'h00, 8'h00);
        add_entry("reset write count", OP_CHECK_WRITES, 18'h20002, 8'h00, 8'h00);
        add_entry("offset 3 zero", OP_READ, 18'h20003, 8'h00, 8'h00);
        add_entry("scratch write", OP_WRITE, 18'h20000, 8'ha5, 8'h00);
        add_entry("scratch rewrite", OP_WRITE, 18'h20000, 8'h3c, 8'h00);
        add_entry("scratch last", OP_READ, 18'h20000, 8'h00, 8'h3c);
        add_entry("poke read count", OP_WRITE, 18'h20001, 8'hff, 8'h00);
        add_entry("poke write count", OP_WRITE, 18'h20002, 8'hff, 8'h00);
        add_entry("poke offset 3", OP_WRITE, 18'h20003, 8'h77, 8'h00);
        add_entry("offset 3 still zero", OP_READ, 18'h20003, 8'h00, 8'h00);
        add_entry("read count kept", OP_CHECK_READS, 18'h20001, 8'h00, 8'h00);
        add_entry("write count kept", OP_CHECK_WRITES, 18'h20002, 8'h00, 8'h00);
        add_entry("first addr write", OP_WRITE, 18'h00000, 8'h11, 8'h00);
        add_entry("second addr write", OP_WRITE, 18'h00001, 8'h22, 8'h00);
        add_entry("last addr write", OP_WRITE, 18'h1ffff, 8'h33, 8'h00);
        add_entry("next to last write", OP_WRITE, 18'h1fffe, 8'h44, 8'h00);
        add_entry("first addr read", OP_READ, 18'h00000, 8'h00, 8'h11);
        add_entry("second addr read", OP_READ, 18'h00001, 8'h00, 8'h22);
        add_entry("last addr read", OP_READ, 18'h1ffff, 8'h00, 8'h33);
        add_entry("next to last read", OP_READ, 18'h1fffe, 8'h00, 8'h44);
        add_entry("second addr rewrite", OP_WRITE, 18'h00001, 8'h99, 8'h00);
        add_entry("first addr intact", OP_READ, 18'h00000, 8'h00, 8'h11);
        add_entry("second addr new", OP_READ, 18'h00001, 8'h00, 8'h99);
        add_entry("sram read count", OP_CHECK_READS, 18'h20001, 8'h00, 8'h00);
        add_entry("sram write count", OP_CHECK_WRITES, 18'h20002, 8'h00, 8'h00);
    endtask

    initial begin
        logic [DATA_WIDTH-1:0]     got;
        logic [DATA_WIDTH-1:0]     want;
        logic [31:0]               seed;
        logic [RAM_ADDR_WIDTH-1:0] rand_addrs [16];
        logic [DATA_WIDTH-1:0]     ref_mem [int];
        wb_reset  = 1'b1;
        wb_addr   = '0;
        wb_wdata  = '0;
        wb_we     = 1'b0;
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        build_table();
        // Table, 32 random accesses and two closing counter reads
        cycle_limit = (ops.size() + 34) * 12 + 200;
        repeat (5) @(posedge wb_clock);
        #1;
        wb_reset = 1'b0;
        @(negedge wb_clock);
        if ({wb_stall, wb_ack, sram_oe, sram_we, sram_data_oe} !== 5'b0) begin
            $display("stall, ack, OE, WE or data enable not low after reset");
            errors++;
        end
        @(posedge wb_clock);
        #1;
        foreach (ops[i]) begin
            want = expects[i];
            if (ops[i] == OP_CHECK_READS) want = sram_reads[7:0];
            if (ops[i] == OP_CHECK_WRITES) want = sram_writes[7:0];
            if (ops[i] == OP_WRITE) access(1'b1, addrs[i], wdatas[i], got);
            else check_read(names[i], addrs[i], want);
        end
        // Random phase, later writes to a repeated address win
        seed = 32'd52;
        for (int i = 0; i < 16; i++) begin
            seed = xorshift32(seed);
            rand_addrs[i] = seed[RAM_ADDR_WIDTH-1:0];
            seed = xorshift32(seed);
            ref_mem[rand_addrs[i]] = seed[DATA_WIDTH-1:0];
            access(1'b1, {1'b0, rand_addrs[i]}, seed[DATA_WIDTH-1:0], got);
        end
        for (int i = 0; i < 16; i++) begin
            check_read($sformatf("random read %0d", i), {1'b0, rand_addrs[i]},
                       ref_mem[rand_addrs[i]]);
        end
        check_read("final read count", 18'h20001, sram_reads[7:0]);
        check_read("final write count", 18'h20002, sram_writes[7:0]);
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        repeat (3) @(posedge wb_clock);
        if (accepts != issued || acks != issued) begin
            $display("handshake count wrong: %0d issued, %0d accepted, %0d acked",
                     issued, accepts, acks);
            errors++;
        end
        $display("errors: %0d, pin rule violations: %0d", errors, violations);
        if (errors == 0 && violations == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sram_model.sv */
module sram_model (
    input  logic                               clock_i,
    input  logic [sram_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic [sram_pkg::DATA_WIDTH-1:0]     data_i,
    input  logic                               data_oe_i,
    input  logic                               oe_i,
    input  logic                               we_i,
    output logic [sram_pkg::DATA_WIDTH-1:0]     data_o,
    output int                                 violations_o
);
    import sram_pkg::*;

    // 128K x 8 storage
    logic [DATA_WIDTH-1:0] mem [0:(1 << RAM_ADDR_WIDTH)-1];
    int                    we_clocks = 0;
    logic                  we_pulse = 1'b0;

    initial violations_o = 0;

    // Chip drives its data pins only while output enabled
    assign data_o = (oe_i === 1'b1) ? mem[addr_i] : 'z;

    // Start of a write pulse
    always @(posedge we_i) begin
        we_clocks = 0;
        we_pulse  = 1'b1;
    end

    // Clocks seen with WE high
    always @(posedge clock_i) begin
        if (we_i === 1'b1) we_clocks++;
        if (oe_i === 1'b1 && we_i === 1'b1) begin
            $display("SRAM model: OE and WE are both high at %0t", $time);
            violations_o++;
        end
        // Bus fight when the controller drives into a chip that is also driving
        if (oe_i === 1'b1 && data_oe_i === 1'b1) begin
            $display("SRAM model: data driven by the controller while OE is high at %0t", $time);
            violations_o++;
        end
        // Write data has to be on the bus for the whole WE pulse
        if (we_i === 1'b1 && data_oe_i !== 1'b1) begin
            $display("SRAM model: WE high without write data driven at %0t", $time);
            violations_o++;
        end
    end

    // Data lands on the trailing edge of WE
    always @(negedge we_i) begin
        if (we_pulse) begin
            mem[addr_i] = data_i;
            we_pulse    = 1'b0;
            if (we_clocks < WRITE_HOLD_COUNT) begin
                $display("SRAM model: WE pulse only %0d clocks long", we_clocks);
                violations_o++;
            end
        end
    end

endmodule

/* sram_subsystem.sv */
module sram_subsystem (
    input  logic                               wb_clock_i,
    input  logic                               wb_reset_i,

    // Wishbone B4 pipelined slave
    input  logic [sram_pkg::BUS_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [sram_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  logic                               wb_we_i,
    input  logic                               wb_cycle_i,
    input  logic                               wb_strobe_i,
    output logic                               wb_stall_o,
    output logic                               wb_ack_o,
    output logic [sram_pkg::DATA_WIDTH-1:0]     wb_data_o,

    // 128K x 8 asynchronous SRAM
    output logic [sram_pkg::RAM_ADDR_WIDTH-1:0] sram_addr_o,
    input  logic [sram_pkg::DATA_WIDTH-1:0]     sram_data_i,
    output logic [sram_pkg::DATA_WIDTH-1:0]     sram_data_o,
    output logic                               sram_data_oe_o,
    output logic                               sram_oe_o,
    output logic                               sram_we_o
);
    import sram_pkg::*;

    // Decoder to targets
    logic    sram_strobe;
    logic    regs_strobe;
    target_e owner;

    // Targets to responder
    logic                  sram_ack;
    logic [DATA_WIDTH-1:0] sram_rdata;
    logic                  regs_ack;
    logic [DATA_WIDTH-1:0] regs_rdata;

    wb_decoder u_decoder (
        .wb_clock_i    (wb_clock_i),
        .wb_reset_i    (wb_reset_i),
        .wb_addr_i     (wb_addr_i),
        .wb_cycle_i    (wb_cycle_i),
        .wb_strobe_i   (wb_strobe_i),
        .wb_ack_i      (wb_ack_o),
        .wb_stall_o    (wb_stall_o),
        .sram_strobe_o (sram_strobe),
        .regs_strobe_o (regs_strobe),
        .owner_o       (owner)
    );

    // Low 17 address bits index the chip
    sram_ctrl u_sram_ctrl (
        .wb_clock_i     (wb_clock_i),
        .wb_reset_i     (wb_reset_i),
        .wb_addr_i      (wb_addr_i[RAM_ADDR_WIDTH-1:0]),
        .wb_data_i      (wb_data_i),
        .wb_we_i        (wb_we_i),
        .strobe_i       (sram_strobe),
        .ack_o          (sram_ack),
        .data_o         (sram_rdata),
        .sram_oe_o      (sram_oe_o),
        .sram_we_o      (sram_we_o),
        .sram_addr_o    (sram_addr_o),
        .sram_data_i    (sram_data_i),
        .sram_data_o    (sram_data_o),
        .sram_data_oe_o (sram_data_oe_o)
    );

    // Low 2 address bits select the register
    sram_regs u_sram_regs (
        .wb_clock_i    (wb_clock_i),
        .wb_reset_i    (wb_reset_i),
        .reg_addr_i    (wb_addr_i[REG_ADDR_WIDTH-1:0]),
        .wb_data_i     (wb_data_i),
        .wb_we_i       (wb_we_i),
        .strobe_i      (regs_strobe),
        .sram_strobe_i (sram_strobe),
        .ack_o         (regs_ack),
        .data_o        (regs_rdata)
    );

    wb_responder u_responder (
        .wb_clock_i  (wb_clock_i),
        .wb_reset_i  (wb_reset_i),
        .owner_i     (owner),
        .sram_ack_i  (sram_ack),
        .sram_data_i (sram_rdata),
        .regs_ack_i  (regs_ack),
        .regs_data_i (regs_rdata),
        .wb_ack_o    (wb_ack_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

/* wb_responder.sv */
module wb_responder (
    input  logic                           wb_clock_i,
    input  logic                           wb_reset_i,
    input  sram_pkg::target_e              owner_i,
    input  logic                           sram_ack_i,
    input  logic [sram_pkg::DATA_WIDTH-1:0] sram_data_i,
    input  logic                           regs_ack_i,
    input  logic [sram_pkg::DATA_WIDTH-1:0] regs_data_i,
    output logic                           wb_ack_o,
    output logic [sram_pkg::DATA_WIDTH-1:0] wb_data_o
);
    import sram_pkg::*;

    logic                  ack_sel;
    logic [DATA_WIDTH-1:0] data_sel;

    // Follow whichever target owns the request
    assign ack_sel  = (owner_i == TARGET_SRAM) ? sram_ack_i : regs_ack_i;
    assign data_sel = (owner_i == TARGET_SRAM) ? sram_data_i : regs_data_i;

    // Bus ack, one clock wide
    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= ack_sel;
        end
    end

    // Read data held after the ack until the next one
    always_ff @(posedge wb_clock_i) begin
        if (ack_sel) begin
            wb_data_o <= data_sel;
        end
    end

    // Target that does not own the request stays silent
    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        (owner_i == TARGET_SRAM) |-> !regs_ack_i)
        else $error("register ack during an SRAM request");

    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        (owner_i == TARGET_REGS) |-> !sram_ack_i)
        else $error("SRAM ack during a register request");

endmodule

/* sram_regs.sv */
module sram_regs (
    input  logic                               wb_clock_i,
    input  logic                               wb_reset_i,
    input  logic [sram_pkg::REG_ADDR_WIDTH-1:0] reg_addr_i,
    input  logic [sram_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  logic                               wb_we_i,
    input  logic                               strobe_i,
    input  logic                               sram_strobe_i,
    output logic                               ack_o,
    output logic [sram_pkg::DATA_WIDTH-1:0]     data_o
);
    import sram_pkg::*;

    reg_offset_e           offset;
    logic [DATA_WIDTH-1:0] scratch_q;
    logic [DATA_WIDTH-1:0] read_count_q;
    logic [DATA_WIDTH-1:0] write_count_q;
    logic [DATA_WIDTH-1:0] read_value;

    assign offset = reg_offset_e'(reg_addr_i);

    // Register readback mux, unused offset reads zero
    always_comb begin
        case (offset)
            REG_SCRATCH:     read_value = scratch_q;
            REG_READ_COUNT:  read_value = read_count_q;
            REG_WRITE_COUNT: read_value = write_count_q;
            default:         read_value = '0;
        endcase
    end

    // Scratch byte, only writable location
    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            scratch_q <= '0;
        end else if (strobe_i && wb_we_i && offset == REG_SCRATCH) begin
            scratch_q <= wb_data_i;
        end
    end

    // SRAM traffic counters, wrap at 256
    // Direction taken from WE of the accepted SRAM request
    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            read_count_q  <= '0;
            write_count_q <= '0;
        end else if (sram_strobe_i) begin
            if (wb_we_i) begin
                write_count_q <= write_count_q + 1'b1;
            end else begin
                read_count_q <= read_count_q + 1'b1;
            end
        end
    end

    // Ack one clock after the strobe
    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= strobe_i;
        end
    end

    // Read data captured with the strobe
    always_ff @(posedge wb_clock_i) begin
        if (strobe_i) begin
            data_o <= read_value;
        end
    end

endmodule

/* sram_ctrl.sv */
module sram_ctrl (
    input  logic                               wb_clock_i,
    input  logic                               wb_reset_i,
    input  logic [sram_pkg::RAM_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [sram_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  logic                               wb_we_i,
    input  logic                               strobe_i,
    output logic                               ack_o,
    output logic [sram_pkg::DATA_WIDTH-1:0]     data_o,

    // Asynchronous SRAM pins
    output logic                               sram_oe_o,
    output logic                               sram_we_o,
    output logic [sram_pkg::RAM_ADDR_WIDTH-1:0] sram_addr_o,
    input  logic [sram_pkg::DATA_WIDTH-1:0]     sram_data_i,
    output logic [sram_pkg::DATA_WIDTH-1:0]     sram_data_o,
    output logic                               sram_data_oe_o
);
    import sram_pkg::*;

    // Read cycle, address and OE rise together
    //   OE high for READ_SETUP_COUNT+1 clocks, data sampled on the last one
    //   Then READ_HOLD_COUNT+1 clocks for the chip to let go of the bus
    //
    // Write cycle, address, WE and data coincident
    //   WE high for WRITE_HOLD_COUNT+1 clocks, setup and hold are zero

    sram_state_e            state_q;
    logic [COUNT_WIDTH-1:0] count_q;

    // Pins and ack decoded straight from the state bits
    assign sram_oe_o      = state_q[1];
    assign sram_we_o      = state_q[2];
    assign ack_o          = state_q[3];
    // Drive the data bus only during the WE pulse
    assign sram_data_oe_o = sram_we_o;

    // Control state
    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            state_q <= READY;
            count_q <= '0;
        end else begin
            case (state_q)
                READY: begin
                    if (strobe_i) begin
                        count_q <= '0;
                        state_q <= wb_we_i ? WRITING : READING;
                    end
                end
                READING: begin
                    // Data valid on the final OE clock
                    if (count_q == COUNT_WIDTH'(READ_SETUP_COUNT)) begin
                        count_q <= '0;
                        state_q <= HIGHZ;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                HIGHZ: begin
                    // Keep the chip idle until its outputs float
                    if (count_q == COUNT_WIDTH'(READ_HOLD_COUNT)) begin
                        count_q <= '0;
                        state_q <= DONE;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                WRITING: begin
                    // Chip writes on the falling edge of WE
                    if (count_q == COUNT_WIDTH'(WRITE_HOLD_COUNT)) begin
                        count_q <= '0;
                        state_q <= DONE;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                DONE: begin
                    // Single ack cycle
                    state_q <= READY;
                end
                default: begin
                    state_q <= READY;
                    count_q <= '0;
                end
            endcase
        end
    end

    // Address and write data captured with the request
    always_ff @(posedge wb_clock_i) begin
        if (state_q == READY && strobe_i) begin
            sram_addr_o <= wb_addr_i;
            sram_data_o <= wb_data_i;
        end
    end

    // Read data sampled at the end of READING, held for the responder
    always_ff @(posedge wb_clock_i) begin
        if (state_q == READING && count_q == COUNT_WIDTH'(READ_SETUP_COUNT)) begin
            data_o <= sram_data_i;
        end
    end

    // Chip never sees OE and WE together
    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        !(sram_oe_o && sram_we_o))
        else $error("OE and WE high together");

    // Address held for the whole strobe and one clock after
    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        (sram_oe_o || sram_we_o) |=> $stable(sram_addr_o))
        else $error("SRAM address changed during an access");

    // Decoder only hands over work when idle
    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        strobe_i |-> (state_q == READY))
        else $error("strobe while controller busy");

endmodule

/* wb_decoder.sv */
module wb_decoder (
    input  logic                               wb_clock_i,
    input  logic                               wb_reset_i,
    input  logic [sram_pkg::BUS_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic                               wb_cycle_i,
    input  logic                               wb_strobe_i,
    input  logic                               wb_ack_i,
    output logic                               wb_stall_o,
    output logic                               sram_strobe_o,
    output logic                               regs_strobe_o,
    output sram_pkg::target_e                  owner_o
);
    import sram_pkg::*;

    logic    busy_q;
    logic    accept;
    target_e target;

    // Top address bit splits SRAM from the register window
    assign target = wb_addr_i[BUS_ADDR_WIDTH-1] ? TARGET_REGS : TARGET_SRAM;

    // Only one request in flight
    assign accept = wb_cycle_i && wb_strobe_i && !busy_q;

    // One-cycle strobe to the addressed target
    assign sram_strobe_o = accept && (target == TARGET_SRAM);
    assign regs_strobe_o = accept && (target == TARGET_REGS);

    // Stall covers the whole outstanding request
    assign wb_stall_o = busy_q;

    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            busy_q  <= 1'b0;
            owner_o <= TARGET_SRAM;
        end else if (accept) begin
            busy_q  <= 1'b1;
            owner_o <= target;
        end else if (wb_ack_i) begin
            // Free again once the bus ack has gone out
            busy_q <= 1'b0;
        end
    end

    // A second request never reaches a target while one is pending
    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        busy_q |-> !(sram_strobe_o || regs_strobe_o))
        else $error("target strobe while a request is outstanding");

    // Bus ack only ever answers an accepted request
    assert property (@(posedge wb_clock_i) disable iff (wb_reset_i)
        wb_ack_i |-> busy_q)
        else $error("bus ack with no request outstanding");

endmodule

/* sram_pkg.sv */
package sram_pkg;

    // Bus clock, fixed for the whole peripheral
    localparam int WB_CLOCK_MHZ = 64;

    // Clock period rounded down to whole nanoseconds
    localparam int CLOCK_NS = 1000 / WB_CLOCK_MHZ;

    // Chip access times in ns, AS6C1008-55 class part
    // OE held until data valid, max of tAA, tOE and tOLZ
    localparam int READ_SETUP_COUNT = (55 + CLOCK_NS - 1) / CLOCK_NS;
    // Output back to high impedance after OE falls
    localparam int READ_HOLD_COUNT = (20 + CLOCK_NS - 1) / CLOCK_NS;
    // Minimum WE pulse width
    localparam int WRITE_HOLD_COUNT = (45 + CLOCK_NS - 1) / CLOCK_NS;

    // Wide enough for the longest of the three phases
    localparam int MAX_PHASE_COUNT =
        (READ_SETUP_COUNT > READ_HOLD_COUNT) ?
            ((READ_SETUP_COUNT > WRITE_HOLD_COUNT) ? READ_SETUP_COUNT : WRITE_HOLD_COUNT) :
            ((READ_HOLD_COUNT > WRITE_HOLD_COUNT) ? READ_HOLD_COUNT : WRITE_HOLD_COUNT);
    localparam int COUNT_WIDTH = $clog2(MAX_PHASE_COUNT + 1);

    // Bus and chip widths
    localparam int BUS_ADDR_WIDTH = 18;
    localparam int RAM_ADDR_WIDTH = 17;
    localparam int DATA_WIDTH = 8;
    localparam int REG_ADDR_WIDTH = 2;

    // Controller states, bits are ack, WE, OE, stall
    typedef enum logic [3:0] {
        READY   = 4'b0000,
        READING = 4'b0011,
        HIGHZ   = 4'b0001,
        WRITING = 4'b0101,
        DONE    = 4'b1000
    } sram_state_e;

    // Owner of the outstanding request
    typedef enum logic {
        TARGET_SRAM = 1'b0,
        TARGET_REGS = 1'b1
    } target_e;

    // Register window offsets
    typedef enum logic [1:0] {
        REG_SCRATCH     = 2'd0,
        REG_READ_COUNT  = 2'd1,
        REG_WRITE_COUNT = 2'd2
    } reg_offset_e;

endpackage
